/* pixel_pkg.sv */
// ********************
// Pixel stream package
// Widths, frame size, stream and statistics types
// ********************
package pixel_pkg;

  // ********************
  // Pixel and frame size
  // ********************
  localparam int PIXEL_BITS = 10; // RAW10
  localparam int NUM_COLS   = 16; // Active columns, even
  localparam int NUM_ROWS   = 8;  // Active rows, even

  // One spare bit so the full count fits
  localparam int COL_BITS = $clog2(NUM_COLS) + 1;
  localparam int ROW_BITS = $clog2(NUM_ROWS) + 1;

  // Pixels per Bayer channel is a power of two
  localparam int CHAN_SHIFT = $clog2((NUM_COLS * NUM_ROWS) / 4);
  localparam int SUM_BITS   = PIXEL_BITS + CHAN_SHIFT; // Channel sum, no overflow

  localparam int FRAME_CNT_BITS = 32;

  // ********************
  // Stream types
  // ********************
  // One pixel beat with its frame and line valid
  typedef struct packed {
    logic                  fv;   // Frame valid
    logic                  lv;   // Line valid
    logic [PIXEL_BITS-1:0] data; // Raw pixel
  } pixel_t;

  // Per-frame statistics, refreshed on the frame interrupt
  typedef struct packed {
    logic [3:0][PIXEL_BITS-1:0] avg;    // Bayer channel averages
    logic [COL_BITS-1:0]        cols;   // Length of last line
    logic [ROW_BITS-1:0]        rows;   // Lines in the frame
    logic [FRAME_CNT_BITS-1:0]  frames; // Running frame count
  } stats_t;

endpackage

/* timing_pkg.sv */
// ********************
// Pattern timing package
// Porches, colorbar constants and raster states
// ********************
package timing_pkg;

  // Vertical timing around the active lines
  localparam int V_FRONT_PORCH = 2; // fv low
  localparam int V_SYNCH       = 2; // fv high before first line
  localparam int V_BACK_PORCH  = 4; // fv high after last line
  localparam int H_BLANK       = 3; // Gap between lines

  // Sum of all phase lengths bounds the longest one
  localparam int PHASE_BITS = $clog2(V_FRONT_PORCH + V_SYNCH + V_BACK_PORCH + H_BLANK);

  // fv stretch ahead of the MIPI transmitter
  localparam int FV_EXT_CYCLES = 6;
  localparam int FV_EXT_BITS   = $clog2(FV_EXT_CYCLES + 1);

  // Colorbar
  localparam int NUM_BARS = 8;
  localparam int BAR_STEP = 128; // Level step per bar

  // Raster phases of the pattern frame
  typedef enum logic [2:0] {
    RS_IDLE,
    RS_FRONT,
    RS_SYNC,
    RS_ACTIVE,
    RS_BLANK,
    RS_BACK
  } raster_state_e;

endpackage

/* raster_counter.sv */
// ********************
// Raster counters for the pattern generator
// Phase, column and row counts under FSM control
// ********************
`timescale 1ns/100ps

module raster_counter
  import pixel_pkg::*;
  import timing_pkg::*;
(
  input  logic                pixel_clk_i,
  input  logic                rst_n_i,
  input  logic                phase_clear_i, // New state entered
  input  logic                col_en_i,      // Active line
  input  logic                row_en_i,      // End of a line
  input  raster_state_e       state_i,
  output logic                phase_done_o,
  output logic [COL_BITS-1:0] col_o,
  output logic                col_last_o,
  output logic                row_last_o
);

  logic [PHASE_BITS-1:0] phase_q;
  logic [PHASE_BITS-1:0] phase_last; // Final count of the current phase
  logic [COL_BITS-1:0]   col_q;
  logic [ROW_BITS-1:0]   row_q;

  // Phase length by state
  always_comb begin
    case (state_i)
      RS_FRONT: phase_last = PHASE_BITS'(V_FRONT_PORCH - 1);
      RS_SYNC:  phase_last = PHASE_BITS'(V_SYNCH - 1);
      RS_BLANK: phase_last = PHASE_BITS'(H_BLANK - 1);
      RS_BACK:  phase_last = PHASE_BITS'(V_BACK_PORCH - 1);
      default:  phase_last = '0; // Idle and active ignore it
    endcase
  end

  always_ff @(posedge pixel_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= '0;
      col_q   <= '0;
      row_q   <= '0;
    end else begin
      phase_q <= phase_clear_i ? '0 : phase_q + 1'b1;
      // Column runs only inside a line
      if (col_en_i) begin
        col_q <= col_last_o ? '0 : col_q + 1'b1;
      end else begin
        col_q <= '0;
      end
      // Rows live between sync and back porch
      if (row_en_i) begin
        row_q <= row_q + 1'b1;
      end else if (state_i != RS_ACTIVE && state_i != RS_BLANK) begin
        row_q <= '0;
      end
    end
  end

  assign phase_done_o = (phase_q == phase_last);
  assign col_o        = col_q;
  assign col_last_o   = (col_q == COL_BITS'(NUM_COLS - 1));
  assign row_last_o   = (row_q == ROW_BITS'(NUM_ROWS - 1)); // Checked at line end

endmodule

/* raster_fsm.sv */
// ********************
// Raster FSM of the colorbar pattern
// Sequences porches and lines, drives pattern fv and lv
// ********************
`timescale 1ns/100ps

module raster_fsm
  import timing_pkg::*;
(
  input  logic          pixel_clk_i,
  input  logic          rst_n_i,
  input  logic          pattern_en_i,
  input  logic          phase_done_i,
  input  logic          col_last_i,
  input  logic          row_last_i,
  output raster_state_e state_o,
  output logic          phase_clear_o,
  output logic          col_en_o,
  output logic          row_en_o,
  output logic          patt_fv_o,
  output logic          patt_lv_o
);

  raster_state_e state_q;
  raster_state_e state_d;

  // ********************
  // Next state
  // ********************
  always_comb begin
    state_d = state_q;
    case (state_q)
      RS_IDLE: begin
        if (pattern_en_i) begin
          state_d = RS_FRONT;
        end
      end
      RS_FRONT: begin
        if (phase_done_i) begin
          state_d = RS_SYNC;
        end
      end
      RS_SYNC: begin
        if (phase_done_i) begin
          state_d = RS_ACTIVE;
        end
      end
      RS_ACTIVE: begin
        if (col_last_i) begin
          state_d = row_last_i ? RS_BACK : RS_BLANK; // Last line skips blank
        end
      end
      RS_BLANK: begin
        if (phase_done_i) begin
          state_d = RS_ACTIVE;
        end
      end
      RS_BACK: begin
        if (phase_done_i) begin
          state_d = pattern_en_i ? RS_FRONT : RS_IDLE; // Stop only between frames
        end
      end
      default: state_d = RS_IDLE;
    endcase
  end

  // ********************
  // State and valid registers
  // ********************
  always_ff @(posedge pixel_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= RS_IDLE;
      patt_fv_o <= 1'b0;
      patt_lv_o <= 1'b0;
    end else begin
      state_q   <= state_d;
      // Levels line up with the registered state
      patt_fv_o <= (state_d == RS_SYNC) || (state_d == RS_ACTIVE) ||
                   (state_d == RS_BLANK) || (state_d == RS_BACK);
      patt_lv_o <= (state_d == RS_ACTIVE);
    end
  end

  assign state_o       = state_q;
  assign phase_clear_o = (state_d != state_q); // Restart phase count on every change
  assign col_en_o      = (state_q == RS_ACTIVE);
  assign row_en_o      = (state_q == RS_ACTIVE) && col_last_i;

endmodule

/* colorbar_data.sv */
// ********************
// Colorbar pixel former
// Bar level from the column, registered with fv and lv
// ********************
`timescale 1ns/100ps

module colorbar_data
  import pixel_pkg::*;
  import timing_pkg::*;
(
  input  logic                pixel_clk_i,
  input  logic                rst_n_i,
  input  logic [COL_BITS-1:0] col_i,
  input  logic                fv_i,
  input  logic                lv_i,
  output pixel_t              patt_pixel_o
);

  logic [PIXEL_BITS-1:0] level;

  // Bar index first, then scale to a level; black outside lines
  assign level = lv_i ? PIXEL_BITS'(((int'(col_i) * NUM_BARS) / NUM_COLS) * BAR_STEP) : '0;

  always_ff @(posedge pixel_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      patt_pixel_o <= '0;
    end else begin
      patt_pixel_o.fv   <= fv_i;
      patt_pixel_o.lv   <= lv_i;
      patt_pixel_o.data <= level; // One cycle latency
    end
  end

endmodule

/* tx_stream_stage.sv */
// ********************
// Transmit stream stage
// Source select, output register and fv one-shot stretch
// ********************
`timescale 1ns/100ps

module tx_stream_stage
  import pixel_pkg::*;
  import timing_pkg::*;
(
  input  logic   pixel_clk_i,
  input  logic   rst_n_i,
  input  logic   pattern_en_i, // Static while fv is low
  input  pixel_t cam_pixel_i,
  input  pixel_t patt_pixel_i,
  output pixel_t tx_pixel_o
);

  pixel_t                 src;
  pixel_t                 pix_q;   // Registered source
  logic [FV_EXT_BITS-1:0] ext_cnt; // One-shot remaining cycles
  logic                   fv_fall;

  assign src     = pattern_en_i ? patt_pixel_i : cam_pixel_i;
  assign fv_fall = pix_q.fv & ~src.fv; // Source frame just ended

  always_ff @(posedge pixel_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pix_q   <= '0;
      ext_cnt <= '0;
    end else begin
      pix_q <= src;
      // ********************
      // One-shot
      // ********************
      if (fv_fall) begin
        ext_cnt <= FV_EXT_BITS'(FV_EXT_CYCLES);
      end else if (ext_cnt != '0) begin
        ext_cnt <= ext_cnt - 1'b1;
      end
    end
  end

  // Stretched fv keeps the MIPI packetizer in frame
  always_comb begin
    tx_pixel_o    = pix_q;
    tx_pixel_o.fv = pix_q.fv | (ext_cnt != '0);
  end

endmodule

/* image_stats.sv */
// ********************
// Image statistics
// Bayer channel averages, frame size and frame count
// ********************
`timescale 1ns/100ps

module image_stats
  import pixel_pkg::*;
(
  input  logic   pixel_clk_i,
  input  logic   rst_n_i,
  input  pixel_t cam_pixel_i,
  output stats_t stats_o,
  output logic   stats_valid_o // Frame interrupt
);

  logic                     fv_q;
  logic                     lv_q;
  logic                     pix_on;    // Active pixel this cycle
  logic                     line_end;
  logic                     frame_end;
  logic [COL_BITS-1:0]      col_cnt;   // Pixels so far in this line
  logic [ROW_BITS-1:0]      row_cnt;   // Lines done in this frame
  logic [COL_BITS-1:0]      line_len;  // Length of last finished line
  logic [1:0]               chan;
  logic [3:0][SUM_BITS-1:0] sum;

  assign pix_on    = cam_pixel_i.fv & cam_pixel_i.lv;
  assign line_end  = lv_q & ~cam_pixel_i.lv;
  assign frame_end = fv_q & ~cam_pixel_i.fv;
  assign chan      = {row_cnt[0], col_cnt[0]}; // Row parity selects the pair

  // ********************
  // Line and frame tracking
  // ********************
  always_ff @(posedge pixel_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fv_q     <= 1'b0;
      lv_q     <= 1'b0;
      col_cnt  <= '0;
      row_cnt  <= '0;
      line_len <= '0;
    end else begin
      fv_q    <= cam_pixel_i.fv;
      lv_q    <= cam_pixel_i.lv;
      col_cnt <= pix_on ? col_cnt + 1'b1 : '0;
      if (line_end) begin
        line_len <= col_cnt;
      end
      if (frame_end) begin
        row_cnt <= '0;
      end else if (line_end) begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

  // ********************
  // Accumulate and publish
  // ********************
  always_ff @(posedge pixel_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sum           <= '0;
      stats_o       <= '0;
      stats_valid_o <= 1'b0;
    end else begin
      stats_valid_o <= frame_end;
      if (frame_end) begin
        for (int i = 0; i < 4; i++) begin
          stats_o.avg[i] <= sum[i][SUM_BITS-1:CHAN_SHIFT]; // Divide by channel pixels
        end
        // lv may drop together with fv
        stats_o.cols   <= line_end ? col_cnt : line_len;
        stats_o.rows   <= row_cnt + ROW_BITS'(line_end);
        stats_o.frames <= stats_o.frames + 1'b1;
        sum            <= '0;
      end else if (pix_on) begin
        sum[chan] <= sum[chan] + SUM_BITS'(cam_pixel_i.data);
      end
    end
  end

endmodule

/* fpga_pixel_core.sv */
// ********************
// Pixel clock core of the FPGA
// Pattern generator, transmit stage and statistics
// ********************
`timescale 1ns/100ps

module fpga_pixel_core
  import pixel_pkg::*;
  import timing_pkg::*;
(
  input  logic   pixel_clk_i,
  input  logic   rst_n_i,
  input  logic   pattern_en_i, // Colorbar instead of camera
  input  pixel_t cam_pixel_i,
  output pixel_t tx_pixel_o,
  output stats_t stats_o,
  output logic   stats_valid_o
);

  raster_state_e       state;
  logic                phase_clear;
  logic                col_en;
  logic                row_en;
  logic                phase_done;
  logic                col_last;
  logic                row_last;
  logic [COL_BITS-1:0] col;
  logic                patt_fv;
  logic                patt_lv;
  pixel_t              patt_pixel;

  // ********************
  // Colorbar generator
  // ********************
  raster_fsm i_raster_fsm (
    .pixel_clk_i  (pixel_clk_i ),
    .rst_n_i      (rst_n_i     ),
    .pattern_en_i (pattern_en_i),
    .phase_done_i (phase_done  ),
    .col_last_i   (col_last    ),
    .row_last_i   (row_last    ),
    .state_o      (state       ),
    .phase_clear_o(phase_clear ),
    .col_en_o     (col_en      ),
    .row_en_o     (row_en      ),
    .patt_fv_o    (patt_fv     ),
    .patt_lv_o    (patt_lv     )
  );

  raster_counter i_raster_counter (
    .pixel_clk_i  (pixel_clk_i),
    .rst_n_i      (rst_n_i    ),
    .phase_clear_i(phase_clear),
    .col_en_i     (col_en     ),
    .row_en_i     (row_en     ),
    .state_i      (state      ),
    .phase_done_o (phase_done ),
    .col_o        (col        ),
    .col_last_o   (col_last   ),
    .row_last_o   (row_last   )
  );

  colorbar_data i_colorbar_data (
    .pixel_clk_i (pixel_clk_i),
    .rst_n_i     (rst_n_i    ),
    .col_i       (col        ),
    .fv_i        (patt_fv    ),
    .lv_i        (patt_lv    ),
    .patt_pixel_o(patt_pixel )
  );

  // ********************
  // Transmit path and statistics
  // ********************
  tx_stream_stage i_tx_stream_stage (
    .pixel_clk_i (pixel_clk_i ),
    .rst_n_i     (rst_n_i     ),
    .pattern_en_i(pattern_en_i),
    .cam_pixel_i (cam_pixel_i ),
    .patt_pixel_i(patt_pixel  ),
    .tx_pixel_o  (tx_pixel_o  )
  );

  image_stats i_image_stats (
    .pixel_clk_i  (pixel_clk_i  ),
    .rst_n_i      (rst_n_i      ),
    .cam_pixel_i  (cam_pixel_i  ), // Always the camera, also in pattern mode
    .stats_o      (stats_o      ),
    .stats_valid_o(stats_valid_o)
  );

endmodule

/* fpga_pixel_core_assertions.sv */
// ********************
// Bound checks on the pixel core outputs
// ********************
`timescale 1ns/100ps

module fpga_pixel_core_assertions
  import pixel_pkg::*;
(
  input logic   pixel_clk_i,
  input logic   rst_n_i,
  input pixel_t tx_pixel_i,
  input logic   stats_valid_i // Frame interrupt
);

  int fail_cnt = 0; // Failed assertions so far

  // Line valid only inside a frame
  a_lv_in_frame: assert property (
    @(posedge pixel_clk_i) disable iff (!rst_n_i) tx_pixel_i.lv |-> tx_pixel_i.fv
  ) else begin
    $error("tx lv high while tx fv is low");
    fail_cnt++;
  end

  a_valid_pulse: assert property (
    @(posedge pixel_clk_i) disable iff (!rst_n_i) stats_valid_i |=> !stats_valid_i
  ) else begin
    $error("stats_valid_o held for two cycles");
    fail_cnt++;
  end

  // Transmitter sees no frame while in reset
  a_fv_reset: assert property (
    @(posedge pixel_clk_i) !rst_n_i |-> !tx_pixel_i.fv
  ) else begin
    $error("tx fv high during reset");
    fail_cnt++;
  end

endmodule

/* tb_fpga_pixel_core.sv */
// ********************
// Testbench of the pixel clock core
// Directed tests of passthrough, fv stretch, statistics and colorbar
// ********************
`timescale 1ns/100ps

module tb_fpga_pixel_core
  import pixel_pkg::*;
  import timing_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 1000; // Limit of any single wait
  localparam int LEAD_CYCLES    = 2;    // fv high before the first line

  logic   pixel_clk;
  logic   rst_n;
  logic   pattern_en;
  pixel_t cam_pixel;
  pixel_t tx_pixel;
  stats_t stats;
  logic   stats_valid;

  // Falling edge samples
  pixel_t tx_smp;
  stats_t stats_smp;
  logic   valid_smp;

  // Passthrough reference
  pixel_t cam_d1;       // Driven one cycle ago
  pixel_t cam_d2;       // Driven two cycles ago
  int     stretch_left; // Expected one-shot cycles
  bit     pass_check;   // Camera path selected

  int     chan_sum[4];  // Bayer sums of the last frame
  int     frames_sent;

  fpga_pixel_core i_dut (
    .pixel_clk_i  (pixel_clk  ),
    .rst_n_i      (rst_n      ),
    .pattern_en_i (pattern_en ),
    .cam_pixel_i  (cam_pixel  ),
    .tx_pixel_o   (tx_pixel   ),
    .stats_o      (stats      ),
    .stats_valid_o(stats_valid)
  );

  bind fpga_pixel_core fpga_pixel_core_assertions i_assertions (
    .pixel_clk_i  (pixel_clk_i  ),
    .rst_n_i      (rst_n_i      ),
    .tx_pixel_i   (tx_pixel_o   ),
    .stats_valid_i(stats_valid_o)
  );

  initial begin
    pixel_clk = 1'b0;
    forever #5 pixel_clk = ~pixel_clk; // 100 MHz
  end

  // ********************
  // Failure reporting and compares
  // ********************
  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_failure(input string msg);
    $display("Failure at %0t: %s", $time, msg);
    stop_run();
  endtask

  always @(negedge pixel_clk) begin
    if (i_dut.i_assertions.fail_cnt != 0) begin
      report_failure("a bound assertion on the DUT outputs failed");
    end
  end

  task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp) begin
      $display("** Error @ %0t: %s got fv=%b lv=%b data=%h, expected fv=%b lv=%b data=%h",
               $time, name, got.fv, got.lv, got.data, exp.fv, exp.lv, exp.data);
      stop_run();
    end
  endtask

  task automatic check_stats(input stats_t got, input stats_t exp);
    if (got !== exp) begin
      $display("** Error @ %0t: stats_o got %h, expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error @ %0t: %s got %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("** Error @ %0t: %s got %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  // ********************
  // Stimulus helpers
  // ********************
  function automatic logic [PIXEL_BITS-1:0] random_sample();
    return PIXEL_BITS'($urandom_range(2 ** PIXEL_BITS - 1, 0));
  endfunction

  // Bar level of pixel k in a line
  function automatic logic [PIXEL_BITS-1:0] bar_level(input int k);
    return PIXEL_BITS'(((k * NUM_BARS) / NUM_COLS) * BAR_STEP);
  endfunction

  // Sample outputs and drive the next camera beat in one cycle
  task automatic step(input pixel_t p);
    pixel_t exp;
    @(negedge pixel_clk);
    tx_smp    = tx_pixel;
    stats_smp = stats;
    valid_smp = stats_valid;
    if (cam_d2.fv && !cam_d1.fv) begin
      stretch_left = FV_EXT_CYCLES; // Registered fv just fell
    end else if (stretch_left > 0) begin
      stretch_left--;
    end
    exp    = cam_d1;
    exp.fv = cam_d1.fv || (stretch_left > 0);
    if (pass_check) begin
      check_pixel("tx_pixel_o", tx_smp, exp);
    end
    cam_d2    = cam_d1;
    cam_d1    = p;
    cam_pixel = p;
  endtask

  // Random RAW10 frame ending in the fv drop
  task automatic send_frame();
    pixel_t p;
    foreach (chan_sum[i]) chan_sum[i] = 0;
    p    = '0;
    p.fv = 1'b1;
    repeat (LEAD_CYCLES) begin
      p.data = random_sample();
      step(p);
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        p.lv   = 1'b1;
        p.data = random_sample();
        chan_sum[(r % 2) * 2 + (c % 2)] += int'(p.data); // Row parity picks the pair
        step(p);
      end
      p.lv = 1'b0;
      repeat (H_BLANK) begin
        p.data = random_sample(); // Junk outside lines
        step(p);
      end
    end
    step('0);
    frames_sent++;
  endtask

  task automatic wait_tx_fv_low();
    int cycles;
    cycles = 0;
    step('0);
    while (tx_smp.fv) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_failure("tx fv did not return low");
      end
      step('0);
    end
  endtask

  // ********************
  // Directed tests
  // ********************
  task automatic test_reset_values();
    step('0);
    check_pixel("tx_pixel_o", tx_smp, '0);
    check_stats(stats_smp, '0);
    check_flag("stats_valid_o", valid_smp, 1'b0);
  endtask

  task automatic test_passthrough();
    pass_check = 1'b1; // Every step compares from here on
    send_frame();
    wait_tx_fv_low();
  endtask

  task automatic test_fv_stretch();
    int high_cnt;
    send_frame();
    high_cnt = 0;
    step('0);
    while (tx_smp.fv) begin
      high_cnt++;
      if (high_cnt > TIMEOUT_CYCLES) begin
        report_failure("tx fv stuck high after the camera frame ended");
      end
      step('0);
    end
    check_count("tx fv stretch cycles", high_cnt, FV_EXT_CYCLES);
  endtask

  task automatic test_stats();
    stats_t exp;
    int     cycles;
    send_frame();
    cycles = 0;
    step('0);
    while (!valid_smp) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_failure("no frame interrupt after the camera frame");
      end
      step('0);
    end
    check_count("cycles from fv fall to interrupt", cycles, 0);
    exp = '0;
    for (int i = 0; i < 4; i++) begin
      exp.avg[i] = PIXEL_BITS'(chan_sum[i] >> CHAN_SHIFT);
    end
    exp.cols   = COL_BITS'(NUM_COLS);
    exp.rows   = ROW_BITS'(NUM_ROWS);
    exp.frames = FRAME_CNT_BITS'(frames_sent);
    check_stats(stats_smp, exp);
    step('0);
    check_flag("stats_valid_o", valid_smp, 1'b0); // Single cycle pulse
    wait_tx_fv_low();
  endtask

  task automatic test_pattern();
    pixel_t exp;
    int     pix_idx;
    int     lines;
    int     gap;
    int     frames_seen;
    int     cycles;
    pix_idx     = 0;
    lines       = 0;
    gap         = 0;
    frames_seen = 0;
    cycles      = 0;
    pass_check  = 1'b0;
    pattern_en  = 1'b1; // Both fv low here
    while (frames_seen < 2) begin
      step('0);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_failure("pattern frames did not complete");
      end
      if (tx_smp.lv) begin
        // Gap longer than a blank closes the frame
        if (pix_idx == 0 && lines > 0 && gap > H_BLANK) begin
          check_count("lines per pattern frame", lines, NUM_ROWS);
          frames_seen++;
          lines = 0;
        end
        exp.fv   = 1'b1;
        exp.lv   = 1'b1;
        exp.data = bar_level(pix_idx);
        check_pixel("tx_pixel_o", tx_smp, exp);
        pix_idx++;
      end else begin
        if (pix_idx > 0) begin
          check_count("pixels per pattern line", pix_idx, NUM_COLS);
          lines++;
          pix_idx = 0;
          gap     = 0;
        end
        gap++;
      end
    end
  endtask

  // ********************
  // Main sequence
  // ********************
  initial begin
    int seed_init;
    seed_init    = $urandom(14417);
    rst_n        = 1'b0;
    pattern_en   = 1'b0;
    cam_pixel    = '0;
    cam_d1       = '0;
    cam_d2       = '0;
    stretch_left = 0;
    pass_check   = 1'b0;
    frames_sent  = 0;
    repeat (16) @(posedge pixel_clk);
    @(negedge pixel_clk);
    rst_n = 1'b1;
    test_reset_values();
    test_passthrough();
    test_fv_stretch();
    test_stats();
    test_pattern();
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* fpga_pixel_core.f */
pixel_pkg.sv
timing_pkg.sv
raster_counter.sv
raster_fsm.sv
colorbar_data.sv
tx_stream_stage.sv
image_stats.sv
fpga_pixel_core.sv
fpga_pixel_core_assertions.sv
tb_fpga_pixel_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pixel core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fpga_pixel_core -f fpga_pixel_core.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
